// File: design/load_rs_config.svh
/*
 * sizes for the load issue path
 * RS_LEN must equal log2 of RS_SIZE; 4 and 8 entries are supported
 */
`ifndef LOAD_RS_CONFIG_SVH
`define LOAD_RS_CONFIG_SVH

`define XLEN     32  // data and address width
`define PRF_LEN  6   // physical register tag
`define ROB_LEN  5
`define LB_LEN   3

// station depth and index width
`define RS_SIZE  4
`define RS_LEN   2

`endif

// File: design/load_rs_pkg.sv
/*
 * types shared by the load station and the address unit
 * widths come from the config header, which must be seen first
 */
`include "load_rs_config.svh"

package load_rs_pkg;

    // access width of a load
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_t;

    //////////////////////////////////////////////////////////////////////
    // one reservation station slot
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                 base_ready;
        logic [`XLEN-1:0]     base_value;  // base tag while base_ready is low
        logic [`XLEN-1:0]     offset;
        logic [`PRF_LEN-1:0]  dest_preg;
        logic [`ROB_LEN-1:0]  rob_idx;     // passed through untouched
        logic [`LB_LEN-1:0]   lb_idx;      // passed through untouched
        mem_size_t            size;
        logic                 is_signed;
    } rs_entry_t;

endpackage

// File: design/dispatch_if.sv
/*
 * one dispatched load per cycle, valid is a single-cycle strobe
 * valid may only be raised while the station is not full
 */
`include "load_rs_config.svh"

interface dispatch_if;
    import load_rs_pkg::*;

    logic                 valid;
    logic [`PRF_LEN-1:0]  base_preg;   // tag to watch on the CDB
    logic                 base_ready;
    logic [`XLEN-1:0]     base_value;
    logic [`XLEN-1:0]     offset;
    logic [`PRF_LEN-1:0]  dest_preg;
    logic [`ROB_LEN-1:0]  rob_idx;
    logic [`LB_LEN-1:0]   lb_idx;
    mem_size_t            size;
    logic                 is_signed;

    modport source (output valid, base_preg, base_ready, base_value, offset,
                    dest_preg, rob_idx, lb_idx, size, is_signed);
    modport sink   (input valid, base_preg, base_ready, base_value, offset,
                    dest_preg, rob_idx, lb_idx, size, is_signed);
endinterface

// File: design/oldest_select.sv
/*
 * fixed priority pick, lowest set bit wins
 * idx is 0 when none is high
 */
module oldest_select #(
    parameter int   WIDTH = 4,
    localparam int  IDX_W = $clog2(WIDTH)
) (
    input  logic [WIDTH-1:0]  req,
    output logic [IDX_W-1:0]  idx,
    output logic              none
);

    // scan from the top down so the lowest request is written last
    always_comb begin
        idx = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = IDX_W'(i);
            end
        end
    end

    assign none = ~|req;

endmodule

// File: design/load_station.sv
/*
 * load reservation station, one dispatch and one issue per cycle
 * without back-pressure the issued entry is freed at the next edge
 * dispatch must not be raised while full; flush drops every entry
 */
`include "load_rs_config.svh"

module load_station (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     flush,      // commit misprediction
    dispatch_if.sink                 disp,
    input  logic                     cdb_valid,
    input  logic [`PRF_LEN-1:0]      cdb_tag,
    input  logic [`XLEN-1:0]         cdb_value,
    output logic                     issue_valid,
    output load_rs_pkg::rs_entry_t   issue_entry,
    output logic                     full
);
    import load_rs_pkg::*;

    rs_entry_t            entries [`RS_SIZE];
    logic [`RS_SIZE-1:0]  free_vec;     // 1 = slot empty
    logic [`RS_SIZE-1:0]  ready_vec;
    logic [`RS_LEN:0]     count;
    logic [`RS_LEN-1:0]   free_idx;
    logic [`RS_LEN-1:0]   pick_idx;
    logic                 free_none;
    logic                 ready_none;
    logic                 cdb_hit;      // CDB matches the load being dispatched
    rs_entry_t            new_entry;

    //////////////////////////////////////////////////////////////////////
    // slot search and issue pick
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            ready_vec[i] = !free_vec[i] && entries[i].base_ready;
        end
    end

    oldest_select #(.WIDTH(`RS_SIZE)) i_free_select (
        .req  (free_vec),
        .idx  (free_idx),
        .none (free_none)
    );

    oldest_select #(.WIDTH(`RS_SIZE)) i_issue_select (
        .req  (ready_vec),
        .idx  (pick_idx),
        .none (ready_none)
    );

    assign issue_valid = !ready_none;
    assign issue_entry = entries[pick_idx];
    assign full        = (count == `RS_SIZE);

    //////////////////////////////////////////////////////////////////////
    // incoming entry, with same-cycle CDB forwarding
    //////////////////////////////////////////////////////////////////////
    assign cdb_hit = cdb_valid && !disp.base_ready && (cdb_tag == disp.base_preg);

    always_comb begin
        new_entry.base_ready = disp.base_ready || cdb_hit;
        if (disp.base_ready) begin
            new_entry.base_value = disp.base_value;
        end else if (cdb_hit) begin
            new_entry.base_value = cdb_value;
        end else begin
            new_entry.base_value = {{(`XLEN-`PRF_LEN){1'b0}}, disp.base_preg}; // park the tag
        end
        new_entry.offset    = disp.offset;
        new_entry.dest_preg = disp.dest_preg;
        new_entry.rob_idx   = disp.rob_idx;
        new_entry.lb_idx    = disp.lb_idx;
        new_entry.size      = disp.size;
        new_entry.is_signed = disp.is_signed;
    end

    //////////////////////////////////////////////////////////////////////
    // entry storage and wakeup
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (cdb_valid && !free_vec[i] && !entries[i].base_ready &&
                entries[i].base_value[`PRF_LEN-1:0] == cdb_tag) begin
                entries[i].base_ready <= 1'b1;
                entries[i].base_value <= cdb_value;  // tag replaced by the value
            end
        end
        if (disp.valid) begin
            entries[free_idx] <= new_entry;  // only ever a free slot
        end
    end

    // occupancy
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            free_vec <= '1;
            count    <= '0;
        end else begin
            count <= count + (`RS_LEN+1)'(disp.valid) - (`RS_LEN+1)'(issue_valid);
            if (disp.valid) begin
                free_vec[free_idx] <= 1'b0;
            end
            if (issue_valid) begin
                free_vec[pick_idx] <= 1'b1;  // freed one edge after issue
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    a_no_disp_when_full : assert property (
        @(posedge clock) disable iff (rst) disp.valid |-> !full
    ) else $error("dispatch while station full");

    // count and free vector must tell the same story
    a_count_bound : assert property (
        @(posedge clock) disable iff (rst) (count <= `RS_SIZE) && (free_none == full)
    ) else $error("occupancy count out of range or out of step");

    // the picked slot must be occupied and hold a ready base
    a_issue_ready : assert property (
        @(posedge clock) disable iff (rst)
            issue_valid |-> (!free_vec[pick_idx] && issue_entry.base_ready)
    ) else $error("issued entry without a ready base");

endmodule

// File: design/load_agu.sv
/*
 * address generation, one cycle of latency, always accepts
 * misaligned accesses are flagged and still passed on
 */
`include "load_rs_config.svh"

module load_agu (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     issue_valid,
    input  load_rs_pkg::rs_entry_t   issue_entry,
    output logic                     load_valid,
    output logic [`XLEN-1:0]         load_addr,
    output load_rs_pkg::mem_size_t   load_size,
    output logic                     load_signed,
    output logic [`PRF_LEN-1:0]      load_dest,
    output logic [`ROB_LEN-1:0]      load_rob,
    output logic [`LB_LEN-1:0]       load_lb,
    output logic                     load_misaligned
);
    import load_rs_pkg::*;

    logic [`XLEN-1:0]  addr_sum;
    logic              misaligned;

    assign addr_sum = issue_entry.base_value + issue_entry.offset;

    always_comb begin
        case (issue_entry.size)
            HALF:    misaligned = addr_sum[0];
            WORD:    misaligned = |addr_sum[1:0];
            default: misaligned = 1'b0;  // bytes are always aligned
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst || flush) load_valid <= 1'b0;
        else              load_valid <= issue_valid;
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            load_addr       <= addr_sum;
            load_size       <= issue_entry.size;
            load_signed     <= issue_entry.is_signed;
            load_dest       <= issue_entry.dest_preg;
            load_rob        <= issue_entry.rob_idx;
            load_lb         <= issue_entry.lb_idx;
            load_misaligned <= misaligned;
        end
    end

    a_valid_known : assert property (
        @(posedge clock) disable iff (rst) !$isunknown(load_valid)
    ) else $error("load_valid unknown after reset");

endmodule

// File: design/load_issue_top.sv
/*
 * load issue path: reservation station followed by the address unit
 * disp_valid must stay low while full is high
 * a ready load leaves 2 cycles after dispatch, one per cycle
 */
`include "load_rs_config.svh"

module load_issue_top (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     disp_valid,
    input  logic [`PRF_LEN-1:0]      disp_base_preg,
    input  logic                     disp_base_ready,
    input  logic [`XLEN-1:0]         disp_base_value,
    input  logic [`XLEN-1:0]         disp_offset,
    input  logic [`PRF_LEN-1:0]      disp_dest_preg,
    input  logic [`ROB_LEN-1:0]      disp_rob_idx,
    input  logic [`LB_LEN-1:0]       disp_lb_idx,
    input  load_rs_pkg::mem_size_t   disp_size,
    input  logic                     disp_signed,
    input  logic                     cdb_valid,
    input  logic [`PRF_LEN-1:0]      cdb_tag,
    input  logic [`XLEN-1:0]         cdb_value,
    output logic                     full,
    output logic                     load_valid,
    output logic [`XLEN-1:0]         load_addr,
    output load_rs_pkg::mem_size_t   load_size,
    output logic                     load_signed,
    output logic [`PRF_LEN-1:0]      load_dest,
    output logic [`ROB_LEN-1:0]      load_rob,
    output logic [`LB_LEN-1:0]       load_lb,
    output logic                     load_misaligned
);

    load_rs_pkg::rs_entry_t  issue_entry;
    logic                    issue_valid;

    dispatch_if i_disp ();

    // pack the dispatch ports into the bundle
    assign i_disp.valid      = disp_valid;
    assign i_disp.base_preg  = disp_base_preg;
    assign i_disp.base_ready = disp_base_ready;
    assign i_disp.base_value = disp_base_value;
    assign i_disp.offset     = disp_offset;
    assign i_disp.dest_preg  = disp_dest_preg;
    assign i_disp.rob_idx    = disp_rob_idx;
    assign i_disp.lb_idx     = disp_lb_idx;
    assign i_disp.size       = disp_size;
    assign i_disp.is_signed  = disp_signed;

    load_station i_load_station (
        .clock       (clock),
        .rst         (rst),
        .flush       (flush),
        .disp        (i_disp.sink),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry),
        .full        (full)
    );

    load_agu i_load_agu (
        .clock           (clock),
        .rst             (rst),
        .flush           (flush),
        .issue_valid     (issue_valid),
        .issue_entry     (issue_entry),
        .load_valid      (load_valid),
        .load_addr       (load_addr),
        .load_size       (load_size),
        .load_signed     (load_signed),
        .load_dest       (load_dest),
        .load_rob        (load_rob),
        .load_lb         (load_lb),
        .load_misaligned (load_misaligned)
    );

endmodule

// File: verification/load_issue_tb.sv
/*
 * testbench for the load issue path, run from the project root
 * one vector line per clock cycle: inputs first, expected outputs after
 * load fields are compared only while the expected load_valid is high
 */
`include "load_rs_config.svh"

module load_issue_tb;
    import load_rs_pkg::*;

    localparam int    NUM_VECS   = 36;
    localparam int    NUM_COLS   = 24;
    localparam int    MAX_CYCLES = NUM_VECS + 20;
    localparam string VEC_FILE   = "verification/load_vectors.txt";

    // column positions in a vector line
    localparam int C_LINE  = 0;   // line number, catches short or shifted files
    localparam int C_FLUSH = 1;
    localparam int C_DISP  = 2;
    localparam int C_PREG  = 3;
    localparam int C_RDY   = 4;
    localparam int C_BVAL  = 5;
    localparam int C_OFF   = 6;
    localparam int C_DEST  = 7;
    localparam int C_ROB   = 8;
    localparam int C_LB    = 9;
    localparam int C_SIZE  = 10;
    localparam int C_SGN   = 11;
    localparam int C_CDBV  = 12;
    localparam int C_CTAG  = 13;
    localparam int C_CVAL  = 14;
    localparam int C_FULL  = 15;  // expected values from here on
    localparam int C_LV    = 16;
    localparam int C_ADDR  = 17;
    localparam int C_ESIZE = 18;
    localparam int C_ESGN  = 19;
    localparam int C_EDEST = 20;
    localparam int C_EROB  = 21;
    localparam int C_ELB   = 22;
    localparam int C_EMIS  = 23;

    logic                 clock;
    logic                 rst;
    logic                 flush;
    logic                 disp_valid;
    logic [`PRF_LEN-1:0]  disp_base_preg;
    logic                 disp_base_ready;
    logic [`XLEN-1:0]     disp_base_value;
    logic [`XLEN-1:0]     disp_offset;
    logic [`PRF_LEN-1:0]  disp_dest_preg;
    logic [`ROB_LEN-1:0]  disp_rob_idx;
    logic [`LB_LEN-1:0]   disp_lb_idx;
    mem_size_t            disp_size;
    logic                 disp_signed;
    logic                 cdb_valid;
    logic [`PRF_LEN-1:0]  cdb_tag;
    logic [`XLEN-1:0]     cdb_value;
    logic                 full;
    logic                 load_valid;
    logic [`XLEN-1:0]     load_addr;
    mem_size_t            load_size;
    logic                 load_signed;
    logic [`PRF_LEN-1:0]  load_dest;
    logic [`ROB_LEN-1:0]  load_rob;
    logic [`LB_LEN-1:0]   load_lb;
    logic                 load_misaligned;

    logic [31:0]  vec_mem [NUM_VECS*NUM_COLS];
    int           error_count = 0;
    int           check_count = 0;
    int           cycle_count = 0;

    load_issue_top i_load_issue_top (
        .clock           (clock),
        .rst             (rst),
        .flush           (flush),
        .disp_valid      (disp_valid),
        .disp_base_preg  (disp_base_preg),
        .disp_base_ready (disp_base_ready),
        .disp_base_value (disp_base_value),
        .disp_offset     (disp_offset),
        .disp_dest_preg  (disp_dest_preg),
        .disp_rob_idx    (disp_rob_idx),
        .disp_lb_idx     (disp_lb_idx),
        .disp_size       (disp_size),
        .disp_signed     (disp_signed),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .full            (full),
        .load_valid      (load_valid),
        .load_addr       (load_addr),
        .load_size       (load_size),
        .load_signed     (load_signed),
        .load_dest       (load_dest),
        .load_rob        (load_rob),
        .load_lb         (load_lb),
        .load_misaligned (load_misaligned)
    );

    always #2 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // vector handling
    //////////////////////////////////////////////////////////////////////
    task automatic read_vector_file(output bit ok);
        int fd;
        ok = 1'b1;
        for (int i = 0; i < NUM_VECS * NUM_COLS; i++) begin
            vec_mem[i] = ~32'(i);  // never a valid line number
        end
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("vector file %s could not be opened", VEC_FILE);
            ok = 1'b0;
        end else begin
            $fclose(fd);
            $readmemh(VEC_FILE, vec_mem);
            for (int k = 0; k < NUM_VECS && ok; k++) begin
                if (vec_mem[k*NUM_COLS + C_LINE] !== 32'(k)) begin
                    $display("vector file is short or malformed at line %0d", k);
                    ok = 1'b0;
                end
            end
        end
    endtask

    task automatic drive_inputs(input int k);
        int b;
        b = k * NUM_COLS;
        flush           <= vec_mem[b + C_FLUSH][0];
        disp_valid      <= vec_mem[b + C_DISP][0];
        disp_base_preg  <= vec_mem[b + C_PREG][`PRF_LEN-1:0];
        disp_base_ready <= vec_mem[b + C_RDY][0];
        disp_base_value <= vec_mem[b + C_BVAL];
        disp_offset     <= vec_mem[b + C_OFF];
        disp_dest_preg  <= vec_mem[b + C_DEST][`PRF_LEN-1:0];
        disp_rob_idx    <= vec_mem[b + C_ROB][`ROB_LEN-1:0];
        disp_lb_idx     <= vec_mem[b + C_LB][`LB_LEN-1:0];
        disp_size       <= mem_size_t'(vec_mem[b + C_SIZE][1:0]);
        disp_signed     <= vec_mem[b + C_SGN][0];
        cdb_valid       <= vec_mem[b + C_CDBV][0];
        cdb_tag         <= vec_mem[b + C_CTAG][`PRF_LEN-1:0];
        cdb_value       <= vec_mem[b + C_CVAL];
    endtask

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("ERROR %0t %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_outputs(input int k);
        int b;
        b = k * NUM_COLS;
        expect_equal("full", 32'(full), vec_mem[b + C_FULL]);
        expect_equal("load_valid", 32'(load_valid), vec_mem[b + C_LV]);
        if (vec_mem[b + C_LV][0]) begin
            expect_equal("load_addr", load_addr, vec_mem[b + C_ADDR]);
            expect_equal("load_size", 32'(load_size), vec_mem[b + C_ESIZE]);
            expect_equal("load_signed", 32'(load_signed), vec_mem[b + C_ESGN]);
            expect_equal("load_dest", 32'(load_dest), vec_mem[b + C_EDEST]);
            expect_equal("load_rob", 32'(load_rob), vec_mem[b + C_EROB]);
            expect_equal("load_lb", 32'(load_lb), vec_mem[b + C_ELB]);
            expect_equal("load_misaligned", 32'(load_misaligned), vec_mem[b + C_EMIS]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        bit vectors_ok;
        clock           = 1'b0;
        rst             = 1'b1;
        flush           = 1'b0;
        disp_valid      = 1'b0;
        disp_base_preg  = '0;
        disp_base_ready = 1'b0;
        disp_base_value = '0;
        disp_offset     = '0;
        disp_dest_preg  = '0;
        disp_rob_idx    = '0;
        disp_lb_idx     = '0;
        disp_size       = BYTE;
        disp_signed     = 1'b0;
        cdb_valid       = 1'b0;
        cdb_tag         = '0;
        cdb_value       = '0;
        read_vector_file(vectors_ok);

        repeat (3) @(posedge clock);
        rst <= 1'b0;
        if (vectors_ok) begin
            for (int k = 0; k < NUM_VECS; k++) begin
                drive_inputs(k);
                @(negedge clock);  // outputs settled mid-cycle
                compare_outputs(k);
                @(posedge clock);
            end
        end else begin
            error_count++;
        end

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: load_rs.f
+incdir+design
design/load_rs_pkg.sv
design/dispatch_if.sv
design/oldest_select.sv
design/load_station.sv
design/load_agu.sv
design/load_issue_top.sv
verification/load_issue_tb.sv

// File: Makefile
# Verilator build and run for the load issue path
TOP := load_issue_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f load_rs.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/load_vectors.txt
// line flush disp preg rdy base_value offset dest rob lb size sgn cdb_v tag cdb_value
// then expected: full load_valid load_addr size sgn dest rob lb misaligned (all hex)
00 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
01 0 1 00 1 00001000 00000010 05 01 1 2 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
02 0 1 00 1 00002000 00000003 06 02 2 1 1 0 00 00000000  0 0 00000000 0 0 00 00 0 0
03 0 1 00 1 00003001 00000000 07 03 3 0 1 0 00 00000000  0 1 00001010 2 0 05 01 1 0
04 0 1 00 1 00004002 00000000 08 04 4 2 0 0 00 00000000  0 1 00002003 1 1 06 02 2 1
05 0 1 00 1 00005000 00000002 09 05 5 1 0 0 00 00000000  0 1 00003001 0 1 07 03 3 0
06 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 1 00004002 2 0 08 04 4 1
07 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 1 00005002 1 0 09 05 5 0
08 0 1 0A 0 00000000 00000004 0B 06 6 2 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
09 0 0 00 0 00000000 00000000 00 00 0 0 0 1 0C 12345678  0 0 00000000 0 0 00 00 0 0
0A 0 0 00 0 00000000 00000000 00 00 0 0 0 1 0A 00006000  0 0 00000000 0 0 00 00 0 0
0B 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
0C 0 1 0D 0 00000000 00000000 0E 07 7 0 1 1 0D 00007001  0 1 00006004 2 0 0B 06 6 0
0D 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
0E 0 1 10 0 00000000 00000000 11 08 0 2 0 0 00 00000000  0 1 00007001 0 1 0E 07 7 0
0F 0 1 10 0 00000000 00000004 12 09 1 2 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
10 0 1 10 0 00000000 00000008 13 0A 2 1 1 0 00 00000000  0 0 00000000 0 0 00 00 0 0
11 0 1 10 0 00000000 0000000D 14 0B 3 0 1 0 00 00000000  0 0 00000000 0 0 00 00 0 0
12 0 0 00 0 00000000 00000000 00 00 0 0 0 1 10 00008000  1 0 00000000 0 0 00 00 0 0
13 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  1 0 00000000 0 0 00 00 0 0
14 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 1 00008000 2 0 11 08 0 0
15 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 1 00008004 2 0 12 09 1 0
16 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 1 00008008 1 1 13 0A 2 0
17 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 1 0000800D 0 1 14 0B 3 0
18 0 1 15 0 00000000 00000000 16 0C 4 2 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
19 0 1 15 0 00000000 00000000 17 0D 5 2 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
1A 0 1 15 0 00000000 00000000 18 0E 6 2 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
1B 0 1 00 1 00009000 00000000 19 0F 7 2 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
1C 1 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  1 0 00000000 0 0 00 00 0 0
1D 0 0 00 0 00000000 00000000 00 00 0 0 0 1 15 0000A000  0 0 00000000 0 0 00 00 0 0
1E 0 1 00 1 0000B000 00000006 1A 10 0 1 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
1F 0 1 00 1 0000C000 00000001 1B 11 1 2 1 0 00 00000000  0 0 00000000 0 0 00 00 0 0
20 0 1 00 1 0000D000 0000000F 1C 12 2 0 0 0 00 00000000  0 1 0000B006 1 0 1A 10 0 0
21 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 1 0000C001 2 1 1B 11 1 1
22 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 1 0000D00F 0 0 1C 12 2 0
23 0 0 00 0 00000000 00000000 00 00 0 0 0 0 00 00000000  0 0 00000000 0 0 00 00 0 0
